/* hdl/fwd_defs.svh */
`ifndef FWD_DEFS_SVH
`define FWD_DEFS_SVH

// Width of one packet word on every lane and on the output stream
`define FWD_DATA_WIDTH 32

// Address width of a packet buffer
// A buffer holds 2**FWD_ADDR_WIDTH words, so at most 16 words per packet
`define FWD_ADDR_WIDTH 4

// Packet lengths need one extra bit so that a full buffer can be expressed
// (see plen_t in fwd_pkg)

`endif

/* hdl/fwd_pkg.sv */
`default_nettype none

`include "fwd_defs.svh"

package fwd_pkg;

	// One packet word as it travels from a lane to the output
	typedef logic [`FWD_DATA_WIDTH-1:0] data_t;

	// Word address inside a single-packet buffer
	typedef logic [`FWD_ADDR_WIDTH-1:0] addr_t;

	// Packet length in words, one bit wider than an address
	typedef logic [`FWD_ADDR_WIDTH:0] plen_t;

	// Buffer either fills from its lane or holds a finished packet
	typedef enum logic {FILL, HOLD} buf_state_t;

	// Forwarder walks a packet, waits for the last word, then idles one cycle
	typedef enum logic [1:0] {IDLE, READ, DRAIN, GAP} fwd_state_t;

endpackage

`default_nettype wire

/* hdl/fwd_rd_if.sv */
`timescale 1ns/10ps
`default_nettype none

// Read port between a packet holder and the block that reads the packet out
// Read data follows rd_en by one cycle
interface fwd_rd_if;

	// Driven by the reader
	fwd_pkg::addr_t rd_addr;
	logic rd_en;
	// One-cycle pulse that frees the holder after the final word
	logic done;

	// Driven by the holder
	fwd_pkg::data_t rd_data;
	// Stays high for the whole packet and never drops inside it
	logic ready;
	fwd_pkg::plen_t len;

	// The side that owns the packet (a buffer, or the combiner facing the forwarder)
	modport holder (
		input rd_addr,
		input rd_en,
		input done,
		output rd_data,
		output ready,
		output len
	);

	// The side that fetches the packet (the forwarder, or the combiner facing a buffer)
	modport reader (
		output rd_addr,
		output rd_en,
		output done,
		input rd_data,
		input ready,
		input len
	);

endinterface

`default_nettype wire

/* hdl/packet_buffer.sv */
`timescale 1ns/10ps
`default_nettype none

`include "fwd_defs.svh"

// Captures one packet from a lane and holds it until the forwarder is done with it
module packet_buffer (
	input wire logic clk,
	input wire logic reset,
	input wire logic in_valid,
	input wire fwd_pkg::data_t in_data,
	input wire logic in_last,
	output logic in_ready,
	fwd_rd_if.holder rd
);

	localparam int DEPTH = 1 << `FWD_ADDR_WIDTH;

	fwd_pkg::data_t mem [DEPTH];
	fwd_pkg::buf_state_t state;
	// Write pointer, which is also the running word count of the packet
	fwd_pkg::plen_t wr_cnt;
	fwd_pkg::plen_t len_q;
	fwd_pkg::data_t rd_data_q;
	logic wr_en;

	// The lane may only push words while the buffer is filling
	assign in_ready = (state == fwd_pkg::FILL);
	assign wr_en = in_valid && in_ready;

	// Packet is offered to the forwarder for as long as it is held
	assign rd.ready = (state == fwd_pkg::HOLD);
	assign rd.len = len_q;
	assign rd.rd_data = rd_data_q;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= fwd_pkg::FILL;
			wr_cnt <= '0;
		end else begin
			case (state)
				fwd_pkg::FILL: begin
					if (wr_en) begin
						wr_cnt <= wr_cnt + 1'b1;
						// Last word closes the packet, ready rises next cycle
						if (in_last) begin
							state <= fwd_pkg::HOLD;
						end
					end
				end
				fwd_pkg::HOLD: begin
					// Done frees the buffer, ready falls one cycle after it
					if (rd.done) begin
						state <= fwd_pkg::FILL;
						wr_cnt <= '0;
					end
				end
				default: state <= fwd_pkg::FILL;
			endcase
		end
	end

	// Word storage, length capture and the registered read port
	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_cnt[`FWD_ADDR_WIDTH-1:0]] <= in_data;
		end
		if (wr_en && in_last) begin
			len_q <= wr_cnt + 1'b1;
		end
		if (rd.rd_en) begin
			rd_data_q <= mem[rd.rd_addr];
		end
	end

	// While a packet is held the lane source waits and pushes no word
	a_no_write_in_hold: assert property (@(posedge clk) disable iff (reset)
		(state == fwd_pkg::HOLD) |-> !in_valid)
		else $error("packet_buffer saw a word pushed while holding a packet");

	// Forwarder may only release a packet that this buffer actually holds
	a_done_in_hold: assert property (@(posedge clk) disable iff (reset)
		rd.done |-> (state == fwd_pkg::HOLD))
		else $error("packet_buffer saw done outside HOLD");

endmodule

`default_nettype wire

/* hdl/fwd_combine.sv */
`timescale 1ns/10ps
`default_nettype none

// Two-to-one packet combiner that keeps packets in order
// Behaves as a multiplexer whose select may only move between packets
module fwd_combine (
	input wire logic clk,
	input wire logic reset,
	fwd_rd_if.reader left,
	fwd_rd_if.reader right,
	fwd_rd_if.holder fwd
);

	localparam logic SEL_LEFT = 1'b0;
	localparam logic SEL_RIGHT = 1'b1;

	// Set when the previous cycle was a packet boundary
	logic do_select;
	// Choice kept from the last cycle, used while switching is not allowed
	logic sel_saved;
	logic sel;

	// A boundary is one cycle after done, or after a cycle where nothing was ready
	// This relies on ready staying high for the whole of a packet
	always_ff @(posedge clk) begin
		if (reset) begin
			do_select <= 1'b1;
			sel_saved <= SEL_LEFT;
		end else begin
			do_select <= fwd.done || (!left.ready && !right.ready);
			sel_saved <= sel;
		end
	end

	// At a boundary the left side wins a tie, and left is the idle default
	always_comb begin
		if (do_select) begin
			if (left.ready) begin
				sel = SEL_LEFT;
			end else if (right.ready) begin
				sel = SEL_RIGHT;
			end else begin
				sel = SEL_LEFT;
			end
		end else begin
			sel = sel_saved;
		end
	end

	// Address is shared, but strobes only reach the chosen buffer
	assign left.rd_addr = fwd.rd_addr;
	assign right.rd_addr = fwd.rd_addr;
	assign left.rd_en = (sel == SEL_LEFT) && fwd.rd_en;
	assign right.rd_en = (sel == SEL_RIGHT) && fwd.rd_en;
	assign left.done = (sel == SEL_LEFT) && fwd.done;
	assign right.done = (sel == SEL_RIGHT) && fwd.done;

	// Data, ready and length come back from the chosen buffer
	assign fwd.rd_data = (sel == SEL_RIGHT) ? right.rd_data : left.rd_data;
	assign fwd.ready = (sel == SEL_RIGHT) ? right.ready : left.ready;
	assign fwd.len = (sel == SEL_RIGHT) ? right.len : left.len;

	// Inside a packet the chosen side stays offered and the choice must not move
	a_sel_stable: assert property (@(posedge clk) disable iff (reset)
		(fwd.ready && !fwd.done) |=> (fwd.ready && $stable(sel)))
		else $error("fwd_combine switched or lost its packet before done");

endmodule

`default_nettype wire

/* hdl/packet_forwarder.sv */
`timescale 1ns/10ps
`default_nettype none

// Reads the selected packet word by word and drives it out as a strobe stream
module packet_forwarder (
	input wire logic clk,
	input wire logic reset,
	fwd_rd_if.reader src,
	output logic out_valid,
	output fwd_pkg::data_t out_data,
	output logic out_last
);

	fwd_pkg::fwd_state_t state;
	// Index of the next word to read, wide enough to reach a full buffer
	fwd_pkg::plen_t rd_idx;
	logic rd_final;
	// Delayed copies of the read strobe, lined up with the returned data
	logic valid_q;
	logic last_q;

	// Length is stable while ready is high, so it can be compared directly
	assign rd_final = (rd_idx == src.len - 1'b1);

	// Reads run back to back while in READ
	assign src.rd_en = (state == fwd_pkg::READ);
	assign src.rd_addr = fwd_pkg::addr_t'(rd_idx);

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= fwd_pkg::IDLE;
			rd_idx <= '0;
		end else begin
			case (state)
				fwd_pkg::IDLE: begin
					rd_idx <= '0;
					if (src.ready) begin
						state <= fwd_pkg::READ;
					end
				end
				fwd_pkg::READ: begin
					rd_idx <= rd_idx + 1'b1;
					if (rd_final) begin
						state <= fwd_pkg::DRAIN;
					end
				end
				// Final word is on the output in this cycle
				fwd_pkg::DRAIN: state <= fwd_pkg::GAP;
				// One spare cycle so the combiner can pick the next lane
				fwd_pkg::GAP: state <= fwd_pkg::IDLE;
				default: state <= fwd_pkg::IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			valid_q <= 1'b0;
			last_q <= 1'b0;
		end else begin
			valid_q <= src.rd_en;
			last_q <= src.rd_en && rd_final;
		end
	end

	assign out_valid = valid_q;
	assign out_data = src.rd_data;
	// Last word and the buffer release happen in the same cycle
	assign out_last = last_q;
	assign src.done = last_q;

	// Every read goes to a packet that the source still offers, otherwise stale words would leave
	a_read_offered: assert property (@(posedge clk) disable iff (reset)
		src.rd_en |-> src.ready)
		else $error("packet_forwarder read while no packet was offered");

endmodule

`default_nettype wire

/* hdl/fwd_top.sv */
`timescale 1ns/10ps
`default_nettype none

// Two-lane forwarding stage
// Each lane fills its own buffer, the combiner picks one, the forwarder streams it out
module fwd_top (
	input wire logic clk,
	input wire logic reset,
	input wire logic left_in_valid,
	input wire fwd_pkg::data_t left_in_data,
	input wire logic left_in_last,
	output wire logic left_in_ready,
	input wire logic right_in_valid,
	input wire fwd_pkg::data_t right_in_data,
	input wire logic right_in_last,
	output wire logic right_in_ready,
	output wire logic out_valid,
	output wire fwd_pkg::data_t out_data,
	output wire logic out_last
);

	// Read ports from each buffer into the combiner, and from the combiner onwards
	fwd_rd_if left_rd ();
	fwd_rd_if right_rd ();
	fwd_rd_if fwd_rd ();

	packet_buffer left_buf (
		.clk(clk),
		.reset(reset),
		.in_valid(left_in_valid),
		.in_data(left_in_data),
		.in_last(left_in_last),
		.in_ready(left_in_ready),
		.rd(left_rd.holder)
	);

	packet_buffer right_buf (
		.clk(clk),
		.reset(reset),
		.in_valid(right_in_valid),
		.in_data(right_in_data),
		.in_last(right_in_last),
		.in_ready(right_in_ready),
		.rd(right_rd.holder)
	);

	fwd_combine combine (
		.clk(clk),
		.reset(reset),
		.left(left_rd.reader),
		.right(right_rd.reader),
		.fwd(fwd_rd.holder)
	);

	packet_forwarder forwarder (
		.clk(clk),
		.reset(reset),
		.src(fwd_rd.reader),
		.out_valid(out_valid),
		.out_data(out_data),
		.out_last(out_last)
	);

endmodule

`default_nettype wire

/* sim/fwd_checker.sv */
`timescale 1ns/10ps
`default_nettype none

// Watches the DUT ports and keeps the complete packets each lane has handed in
// Every output packet is compared with the head of the lane that should go next
module fwd_checker (
	input wire logic clk,
	input wire logic reset,
	input wire logic left_in_valid,
	input wire fwd_pkg::data_t left_in_data,
	input wire logic left_in_last,
	input wire logic left_in_ready,
	input wire logic right_in_valid,
	input wire fwd_pkg::data_t right_in_data,
	input wire logic right_in_last,
	input wire logic right_in_ready,
	input wire logic out_valid,
	input wire fwd_pkg::data_t out_data,
	input wire logic out_last,
	input wire logic [2:0] test_num,
	input wire logic test_end,
	output int packets_out,
	output int error_count,
	output int tests_failed
);

	// Lane 0 is left, lane 1 is right
	// Words of complete packets, with the length and capture cycle of each packet
	fwd_pkg::data_t lane_words[2][$];
	int lane_lens[2][$];
	int lane_times[2][$];
	// Words of the output packet that is still being collected
	fwd_pkg::data_t out_words[$];
	int fill[2];
	// Set from the last input word until that packet leaves the output
	logic held[2];
	int cycle;
	int test_errors;

	task automatic fail_value(input string msg);
		$display("Fail at %0t: %s", $time, msg);
		error_count++;
		test_errors++;
	endtask

	task automatic fail_other(input string msg);
		$display("Error at %0t: %s", $time, msg);
		error_count++;
		test_errors++;
	endtask

	task automatic capture(input int lane, input logic valid, input fwd_pkg::data_t word,
			input logic last, input logic ready);
		// A lane sees in_ready low exactly while its packet waits in the buffer
		if (ready !== !held[lane]) begin
			fail_value($sformatf("lane %0d in_ready is %b, expected %b", lane, ready, !held[lane]));
		end
		if (valid && ready) begin
			lane_words[lane].push_back(word);
			fill[lane]++;
			if (last) begin
				lane_lens[lane].push_back(fill[lane]);
				lane_times[lane].push_back(cycle);
				fill[lane] = 0;
				held[lane] = 1'b1;
			end
		end
	endtask

	task automatic compare_packet();
		int lane;
		int exp_len;
		fwd_pkg::data_t exp_word;
		logic word_bad;
		if (lane_lens[0].size() == 0 && lane_lens[1].size() == 0) begin
			fail_other("a packet left the output while no input packet was waiting");
			return;
		end
		// The packet completed first goes first, and a tie goes to the left lane
		if (lane_lens[1].size() == 0) begin
			lane = 0;
		end else if (lane_lens[0].size() == 0) begin
			lane = 1;
		end else begin
			lane = (lane_times[0][0] <= lane_times[1][0]) ? 0 : 1;
		end
		exp_len = lane_lens[lane].pop_front();
		void'(lane_times[lane].pop_front());
		if (out_words.size() != exp_len) begin
			fail_value($sformatf("lane %0d packet has %0d words, expected %0d",
				lane, out_words.size(), exp_len));
		end
		word_bad = 1'b0;
		for (int i = 0; i < exp_len; i++) begin
			exp_word = lane_words[lane].pop_front();
			if (!word_bad && i < out_words.size() && out_words[i] !== exp_word) begin
				fail_value($sformatf("lane %0d word %0d is %h, expected %h",
					lane, i, out_words[i], exp_word));
				word_bad = 1'b1;
			end
		end
		held[lane] = 1'b0;
		packets_out++;
	endtask

	task automatic end_test();
		// Once drained, nothing may be left waiting in either lane
		for (int lane = 0; lane < 2; lane++) begin
			if (lane_lens[lane].size() != 0 || fill[lane] != 0) begin
				fail_other($sformatf("lane %0d still holds %0d packets and %0d loose words",
					lane, lane_lens[lane].size(), fill[lane]));
			end
		end
		if (test_errors == 0) begin
			$display("Test %0d: passed", test_num);
		end else begin
			$display("Test %0d: failed with %0d errors", test_num, test_errors);
			tests_failed++;
		end
		test_errors = 0;
	endtask

	always @(posedge clk) begin
		if (reset) begin
			for (int lane = 0; lane < 2; lane++) begin
				lane_words[lane].delete();
				lane_lens[lane].delete();
				lane_times[lane].delete();
				fill[lane] = 0;
				held[lane] = 1'b0;
			end
			out_words.delete();
			cycle = 0;
			test_errors = 0;
			packets_out = 0;
			error_count = 0;
			tests_failed = 0;
		end else begin
			cycle++;
			capture(0, left_in_valid, left_in_data, left_in_last, left_in_ready);
			capture(1, right_in_valid, right_in_data, right_in_last, right_in_ready);
			if (out_last && !out_valid) begin
				fail_value("out_last is high without out_valid");
			end
			if (out_valid) begin
				out_words.push_back(out_data);
				if (out_last) begin
					compare_packet();
					out_words.delete();
				end else if (out_words.size() >= 16) begin
					fail_value("output packet runs past 16 words without out_last");
					out_words.delete();
				end
			end else if (out_words.size() != 0) begin
				// Words of one packet come back to back, so a hole means a broken packet
				fail_value("output packet broken by a cycle without out_valid");
				out_words.delete();
			end
			if (test_end) begin
				end_test();
			end
		end
	end

endmodule

`default_nettype wire

/* sim/fwd_top_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module fwd_top_tb;

	localparam logic [15:0] SEED = 16'd37252;
	localparam int MAX_LEN = 16;
	// Packets per lane in the long random run
	localparam int RANDOM_PACKETS = 24;
	// Tests 1, 2, 3 and 5 send 1, 1, 2 and 4 packets
	localparam int TOTAL_PACKETS = 8 + 2 * RANDOM_PACKETS;
	// Every packet counted at full length, plus reset and the drain after each test
	localparam int TIMEOUT_CYCLES = TOTAL_PACKETS * MAX_LEN * 2 + TOTAL_PACKETS * 8 + 10 + 6 * 8;

	logic clk;
	logic reset;
	logic left_in_valid;
	fwd_pkg::data_t left_in_data;
	logic left_in_last;
	logic left_in_ready;
	logic right_in_valid;
	fwd_pkg::data_t right_in_data;
	logic right_in_last;
	logic right_in_ready;
	logic out_valid;
	fwd_pkg::data_t out_data;
	logic out_last;
	logic [2:0] test_num;
	logic test_end;
	int packets_out;
	int error_count;
	int tests_failed;
	int packets_sent;
	int cycle_count = 0;
	int len;
	logic [15:0] lfsr_state;
	// Planned packets per lane, lane 0 is left
	fwd_pkg::data_t plan_words[2][$];
	int plan_lens[2][$];
	int plan_gaps[2][$];

	fwd_top fwd_top_inst (.*);

	fwd_checker checker_inst (.*);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// 16-bit Fibonacci LFSR with taps 16, 14, 13 and 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	// One LFSR step for every bit taken
	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			r = {r[30:0], lfsr_state[0]};
		end
		return r;
	endfunction

	function automatic int random_len();
		return int'(random_bits(4)) + 1;
	endfunction

	task automatic add_packet(input int lane, input int plen, input int gap);
		for (int i = 0; i < plen; i++) begin
			plan_words[lane].push_back(random_bits(32));
		end
		plan_lens[lane].push_back(plen);
		plan_gaps[lane].push_back(gap);
		packets_sent++;
	endtask

	task automatic drive_word(input int lane, input logic valid, input fwd_pkg::data_t word,
			input logic last);
		if (lane == 0) begin
			left_in_valid = valid;
			left_in_data = word;
			left_in_last = last;
		end else begin
			right_in_valid = valid;
			right_in_data = word;
			right_in_last = last;
		end
	endtask

	// Plays the planned packets of one lane, starting on a falling edge
	task automatic play_lane(input int lane);
		int plen;
		int gap;
		while (plan_lens[lane].size() != 0) begin
			plen = plan_lens[lane].pop_front();
			gap = plan_gaps[lane].pop_front();
			repeat (gap) @(negedge clk);
			for (int i = 0; i < plen; i++) begin
				// The source waits while its buffer still holds the previous packet
				while (!(lane == 0 ? left_in_ready : right_in_ready)) begin
					@(negedge clk);
				end
				drive_word(lane, 1'b1, plan_words[lane].pop_front(), i == plen - 1);
				@(negedge clk);
			end
			drive_word(lane, 1'b0, '0, 1'b0);
		end
	endtask

	task automatic run_test(input logic [2:0] num);
		fork
			play_lane(0);
			play_lane(1);
		join
		while (packets_out != packets_sent) begin
			@(negedge clk);
		end
		repeat (4) @(negedge clk);
		test_num = num;
		test_end = 1'b1;
		@(negedge clk);
		test_end = 1'b0;
	endtask

	initial begin
		lfsr_state = SEED;
		reset = 1'b1;
		left_in_valid = 1'b0;
		left_in_data = '0;
		left_in_last = 1'b0;
		right_in_valid = 1'b0;
		right_in_data = '0;
		right_in_last = 1'b0;
		test_num = '0;
		test_end = 1'b0;
		packets_sent = 0;
		repeat (10) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		add_packet(0, random_len(), 0);
		run_test(3'd1);
		add_packet(1, random_len(), 0);
		run_test(3'd2);
		// Equal lengths started together close in the same cycle on both lanes
		len = random_len();
		add_packet(0, len, 0);
		add_packet(1, len, 0);
		run_test(3'd3);
		for (int i = 0; i < RANDOM_PACKETS; i++) begin
			add_packet(0, random_len(), int'(random_bits(2)));
			add_packet(1, random_len(), int'(random_bits(2)));
		end
		run_test(3'd4);
		// Back to back full packets keep each lane waiting on its in_ready
		for (int i = 0; i < 2; i++) begin
			add_packet(0, MAX_LEN, 0);
			add_packet(1, MAX_LEN, 0);
		end
		run_test(3'd5);
		run_test(3'd6);
		$display("Tests run: 6, failed: %0d, errors: %0d, packets: %0d of %0d",
			tests_failed, error_count, packets_out, packets_sent);
		if (error_count == 0 && tests_failed == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Test failures found");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* compile.f */
+incdir+hdl
hdl/fwd_pkg.sv
hdl/fwd_rd_if.sv
hdl/packet_buffer.sv
hdl/fwd_combine.sv
hdl/packet_forwarder.sv
hdl/fwd_top.sv
sim/fwd_checker.sv
sim/fwd_top_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 --top-module fwd_top_tb -f compile.f -o fwd_top_sim
output=$(./obj_dir/fwd_top_sim)
echo "$output"
if echo "$output" | grep -q 'All tests passed!'; then
	exit 0
fi
exit 1
